/* hw/axil_io_bridge_config.svh */
`ifndef AXIL_IO_BRIDGE_CONFIG_SVH
`define AXIL_IO_BRIDGE_CONFIG_SVH

// AXI4-Lite byte address width
`define AXIL_ADDR_WIDTH 32

// AXI4-Lite data width, also the I/O bus word
`define AXIL_DATA_WIDTH 32

// Scratch memory depth in words
`define IO_MEM_WORDS 256

// Commands allowed in flight between arbiter and memory
`define IO_OUTSTANDING 4

`endif

/* hw/axil_pkg.sv */
`default_nettype none

`include "axil_io_bridge_config.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0]   axil_addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0]   axil_data_t;
  typedef logic [`AXIL_DATA_WIDTH/8-1:0] axil_strb_t;

  // Only the two codes this target ever returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // AW and W joined into one request
  typedef struct packed {
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
  } axil_wr_req_s;

  typedef struct packed {
    axil_addr_t addr;
  } axil_rd_req_s;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_s;

  typedef struct packed {
    axil_data_t data;
    axil_resp_e resp;
  } axil_r_s;

endpackage

`default_nettype wire

/* hw/io_bus_pkg.sv */
`default_nettype none

`include "axil_io_bridge_config.svh"

package io_bus_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0] io_addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0] io_data_t;

  // Uncached accesses only
  typedef enum logic {
    uc_rd = 1'b0,
    uc_wr = 1'b1
  } io_msg_e;

  // Bytes touched, counted from the low lane
  typedef enum logic [1:0] {
    size_1 = 2'd0,
    size_2 = 2'd1,
    size_4 = 2'd2
  } io_size_e;

  typedef struct packed {
    io_msg_e  msg_type;
    io_size_e size;
    io_addr_t addr;
  } io_cmd_hdr_s;

  // err covers any out of range access
  typedef struct packed {
    io_msg_e msg_type;
    logic    err;
  } io_resp_hdr_s;

endpackage

`default_nettype wire

/* hw/axil_write_capture.sv */
`default_nettype none

module axil_write_capture
  (input  wire                         clk_i
  , input  wire                        rst_n_i

  , input  axil_pkg::axil_addr_t       s_awaddr_i
  , input  wire                        s_awvalid_i
  , output logic                       s_awready_o

  , input  axil_pkg::axil_data_t       s_wdata_i
  , input  axil_pkg::axil_strb_t       s_wstrb_i
  , input  wire                        s_wvalid_i
  , output logic                       s_wready_o

  , output axil_pkg::axil_resp_e       s_bresp_o
  , output logic                       s_bvalid_o
  , input  wire                        s_bready_i

  , output axil_pkg::axil_wr_req_s     wr_req_o
  , output logic                       wr_req_v_o
  , input  wire                        wr_req_ready_i

  , input  axil_pkg::axil_b_s          b_i
  , input  wire                        b_v_i
  , output logic                       b_ready_o
  );

  import axil_pkg::*;

  logic       aw_full_q;
  logic       w_full_q;
  logic       req_v_q;
  logic       bvalid_q;
  axil_addr_t aw_addr_q;
  axil_data_t w_data_q;
  axil_strb_t w_strb_q;
  axil_b_s    b_q;

  logic aw_fire;
  logic w_fire;
  logic req_fire;

  assign s_awready_o = !aw_full_q;
  assign s_wready_o  = !w_full_q;
  assign aw_fire     = s_awvalid_i && s_awready_o;
  assign w_fire      = s_wvalid_i && s_wready_o;
  assign req_fire    = req_v_q && wr_req_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      req_v_q   <= 1'b0;
      bvalid_q  <= 1'b0;
    end
    else
    begin
      // Both holding registers free together once the request is taken
      if (req_fire)
      begin
        aw_full_q <= 1'b0;
        w_full_q  <= 1'b0;
        req_v_q   <= 1'b0;
      end
      else
      begin
        if (aw_fire)
          aw_full_q <= 1'b1;
        if (w_fire)
          w_full_q <= 1'b1;
        if (aw_full_q && w_full_q)
          req_v_q <= 1'b1;
      end

      if (b_v_i && b_ready_o)
        bvalid_q <= 1'b1;
      else if (s_bready_i)
        bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (aw_fire)
      aw_addr_q <= s_awaddr_i;
    if (w_fire)
    begin
      w_data_q <= s_wdata_i;
      w_strb_q <= s_wstrb_i;
    end
    if (b_v_i && b_ready_o)
      b_q <= b_i;
  end

  assign wr_req_o.addr = aw_addr_q;
  assign wr_req_o.data = w_data_q;
  assign wr_req_o.strb = w_strb_q;
  assign wr_req_v_o    = req_v_q;

  // One B beat buffered at a time
  assign b_ready_o  = !bvalid_q;
  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = b_q.resp;

  a_awaddr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_awvalid_i && !s_awready_o) |=> (s_awvalid_i && $stable(s_awaddr_i)));

endmodule

`default_nettype wire

/* hw/axil_read_capture.sv */
`default_nettype none

module axil_read_capture
  (input  wire                         clk_i
  , input  wire                        rst_n_i

  , input  axil_pkg::axil_addr_t       s_araddr_i
  , input  wire                        s_arvalid_i
  , output logic                       s_arready_o

  , output axil_pkg::axil_data_t       s_rdata_o
  , output axil_pkg::axil_resp_e       s_rresp_o
  , output logic                       s_rvalid_o
  , input  wire                        s_rready_i

  , output axil_pkg::axil_rd_req_s     rd_req_o
  , output logic                       rd_req_v_o
  , input  wire                        rd_req_ready_i

  , input  axil_pkg::axil_r_s          r_i
  , input  wire                        r_v_i
  , output logic                       r_ready_o
  );

  import axil_pkg::*;

  logic       ar_full_q;
  logic       req_v_q;
  logic       rvalid_q;
  axil_addr_t ar_addr_q;
  axil_r_s    r_q;

  logic ar_fire;

  assign s_arready_o = !ar_full_q;
  assign ar_fire     = s_arvalid_i && s_arready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ar_full_q <= 1'b0;
      req_v_q   <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      if (req_v_q && rd_req_ready_i)
      begin
        ar_full_q <= 1'b0;
        req_v_q   <= 1'b0;
      end
      else if (ar_fire)
        ar_full_q <= 1'b1;
      else if (ar_full_q)
        req_v_q <= 1'b1;

      if (r_v_i && r_ready_o)
        rvalid_q <= 1'b1;
      else if (s_rready_i)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ar_fire)
      ar_addr_q <= s_araddr_i;
    if (r_v_i && r_ready_o)
      r_q <= r_i;
  end

  assign rd_req_o.addr = ar_addr_q;
  assign rd_req_v_o    = req_v_q;

  assign r_ready_o  = !rvalid_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = r_q.data;
  assign s_rresp_o  = r_q.resp;

  a_rvalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_rvalid_o && !s_rready_i) |=> (s_rvalid_o && $stable(s_rdata_o)));

endmodule

`default_nettype wire

/* hw/io_cmd_arbiter.sv */
`default_nettype none

`include "axil_io_bridge_config.svh"

module io_cmd_arbiter
  (input  wire                         clk_i
  , input  wire                        rst_n_i

  , input  axil_pkg::axil_wr_req_s     wr_req_i
  , input  wire                        wr_req_v_i
  , output logic                       wr_req_ready_o

  , input  axil_pkg::axil_rd_req_s     rd_req_i
  , input  wire                        rd_req_v_i
  , output logic                       rd_req_ready_o

  , output axil_pkg::axil_b_s          b_o
  , output logic                       b_v_o
  , input  wire                        b_ready_i

  , output axil_pkg::axil_r_s          r_o
  , output logic                       r_v_o
  , input  wire                        r_ready_i

  , output io_bus_pkg::io_cmd_hdr_s    io_cmd_hdr_o
  , output io_bus_pkg::io_data_t       io_cmd_data_o
  , output logic                       io_cmd_v_o
  , input  wire                        io_cmd_ready_i

  , input  io_bus_pkg::io_resp_hdr_s   io_resp_hdr_i
  , input  io_bus_pkg::io_data_t       io_resp_data_i
  , input  wire                        io_resp_v_i
  , output logic                       io_resp_ready_o
  );

  import axil_pkg::*;
  import io_bus_pkg::*;

  localparam int depth_lp = `IO_OUTSTANDING;
  localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_w_lp = $clog2(depth_lp + 1);

  // Source of each command in flight, 1 for a write
  logic                src_wr_q [depth_lp];
  logic [ptr_w_lp-1:0] wr_ptr_q;
  logic [ptr_w_lp-1:0] rd_ptr_q;
  logic [cnt_w_lp-1:0] count_q;
  logic                prio_wr_q;

  logic fifo_full;
  logic sel_wr;
  logic push;
  logic pop;
  logic head_wr;

  assign fifo_full = (count_q == cnt_w_lp'(depth_lp));

  // Write wins when it holds priority or the read is idle
  assign sel_wr = wr_req_v_i && (prio_wr_q || !rd_req_v_i);

  assign io_cmd_v_o     = (wr_req_v_i || rd_req_v_i) && !fifo_full;
  assign wr_req_ready_o = sel_wr && !fifo_full && io_cmd_ready_i;
  assign rd_req_ready_o = !sel_wr && !fifo_full && io_cmd_ready_i;
  assign push           = io_cmd_v_o && io_cmd_ready_i;

  always_comb
  begin
    io_cmd_hdr_o.msg_type = sel_wr ? uc_wr : uc_rd;
    io_cmd_hdr_o.addr     = sel_wr ? wr_req_i.addr : rd_req_i.addr;
    io_cmd_data_o         = sel_wr ? wr_req_i.data : '0;
    io_cmd_hdr_o.size     = size_4;
    if (sel_wr)
    begin
      case (wr_req_i.strb)
        axil_strb_t'('h1): io_cmd_hdr_o.size = size_1;
        axil_strb_t'('h3): io_cmd_hdr_o.size = size_2;
        default:           io_cmd_hdr_o.size = size_4;
      endcase
    end
  end

  // Responses come back in command order
  assign head_wr         = src_wr_q[rd_ptr_q];
  assign b_v_o           = io_resp_v_i && head_wr;
  assign r_v_o           = io_resp_v_i && !head_wr;
  assign io_resp_ready_o = head_wr ? b_ready_i : r_ready_i;
  assign pop             = io_resp_v_i && io_resp_ready_o;

  assign b_o.resp = io_resp_hdr_i.err ? SLVERR : OKAY;
  assign r_o.resp = io_resp_hdr_i.err ? SLVERR : OKAY;
  assign r_o.data = io_resp_data_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      prio_wr_q <= 1'b1;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q  <= (wr_ptr_q == ptr_w_lp'(depth_lp - 1)) ? '0 : wr_ptr_q + 1'b1;
        prio_wr_q <= !sel_wr;
      end
      if (pop)
        rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_lp - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      src_wr_q[wr_ptr_q] <= sel_wr;
  end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop |-> (count_q != '0));

  a_resp_matches_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_resp_v_i |-> ((io_resp_hdr_i.msg_type == uc_wr) == head_wr));

endmodule

`default_nettype wire

/* hw/io_scratch_mem.sv */
`default_nettype none

`include "axil_io_bridge_config.svh"

module io_scratch_mem
  (input  wire                         clk_i
  , input  wire                        rst_n_i

  , input  io_bus_pkg::io_cmd_hdr_s    io_cmd_hdr_i
  , input  io_bus_pkg::io_data_t       io_cmd_data_i
  , input  wire                        io_cmd_v_i
  , output logic                       io_cmd_ready_o

  , output io_bus_pkg::io_resp_hdr_s   io_resp_hdr_o
  , output io_bus_pkg::io_data_t       io_resp_data_o
  , output logic                       io_resp_v_o
  , input  wire                        io_resp_ready_i
  );

  import io_bus_pkg::*;

  localparam int words_lp  = `IO_MEM_WORDS;
  localparam int idx_w_lp  = $clog2(words_lp);
  localparam int bytes_lp  = $bits(io_data_t) / 8;
  localparam int addr_w_lp = $bits(io_addr_t);

  typedef enum logic {
    idle,
    resp_hold
  } mem_state_e;

  mem_state_e          state_q;
  io_data_t            mem_q [words_lp];
  io_resp_hdr_s        resp_hdr_q;
  io_data_t            resp_data_q;

  logic                cmd_fire;
  logic [idx_w_lp-1:0] cmd_idx;
  logic                cmd_err;
  logic [bytes_lp-1:0] lane_mask;

  // Stall only when the held response cannot leave this cycle
  assign io_cmd_ready_o = !(state_q == resp_hold && !io_resp_ready_i);
  assign cmd_fire       = io_cmd_v_i && io_cmd_ready_o;

  assign cmd_idx = io_cmd_hdr_i.addr[idx_w_lp+1:2];
  assign cmd_err = (io_cmd_hdr_i.addr[addr_w_lp-1:idx_w_lp+2] != '0)
                || (int'(cmd_idx) >= words_lp);

  always_comb
  begin
    unique case (io_cmd_hdr_i.size)
      size_1:  lane_mask = bytes_lp'('b1);
      size_2:  lane_mask = bytes_lp'('b11);
      default: lane_mask = '1;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= idle;
      for (int i = 0; i < words_lp; i++)
        mem_q[i] <= '0;
    end
    else
    begin
      unique case (state_q)
        idle:
          if (cmd_fire)
            state_q <= resp_hold;
        resp_hold:
          if (io_resp_ready_i && !cmd_fire)
            state_q <= idle;
      endcase

      // Out of range writes leave the array untouched
      if (cmd_fire && io_cmd_hdr_i.msg_type == uc_wr && !cmd_err)
      begin
        for (int b = 0; b < bytes_lp; b++)
          if (lane_mask[b])
            mem_q[cmd_idx][8*b +: 8] <= io_cmd_data_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_hdr_q.msg_type <= io_cmd_hdr_i.msg_type;
      resp_hdr_q.err      <= cmd_err;
      if (io_cmd_hdr_i.msg_type == uc_rd && !cmd_err)
        resp_data_q <= mem_q[cmd_idx];
      else
        resp_data_q <= '0;
    end
  end

  assign io_resp_v_o    = (state_q == resp_hold);
  assign io_resp_hdr_o  = resp_hdr_q;
  assign io_resp_data_o = resp_data_q;

endmodule

`default_nettype wire

/* hw/axil_io_bridge_top.sv */
`default_nettype none

module axil_io_bridge_top
  (input  wire                         clk_i
  , input  wire                        rst_n_i

  , input  axil_pkg::axil_addr_t       s_awaddr_i
  , input  wire                        s_awvalid_i
  , output logic                       s_awready_o

  , input  axil_pkg::axil_data_t       s_wdata_i
  , input  axil_pkg::axil_strb_t       s_wstrb_i
  , input  wire                        s_wvalid_i
  , output logic                       s_wready_o

  , output axil_pkg::axil_resp_e       s_bresp_o
  , output logic                       s_bvalid_o
  , input  wire                        s_bready_i

  , input  axil_pkg::axil_addr_t       s_araddr_i
  , input  wire                        s_arvalid_i
  , output logic                       s_arready_o

  , output axil_pkg::axil_data_t       s_rdata_o
  , output axil_pkg::axil_resp_e       s_rresp_o
  , output logic                       s_rvalid_o
  , input  wire                        s_rready_i
  );

  import axil_pkg::*;
  import io_bus_pkg::*;

  axil_wr_req_s wr_req;
  logic         wr_req_v;
  logic         wr_req_ready;
  axil_rd_req_s rd_req;
  logic         rd_req_v;
  logic         rd_req_ready;
  axil_b_s      b;
  logic         b_v;
  logic         b_ready;
  axil_r_s      r;
  logic         r_v;
  logic         r_ready;

  io_cmd_hdr_s  io_cmd_hdr;
  io_data_t     io_cmd_data;
  logic         io_cmd_v;
  logic         io_cmd_ready;
  io_resp_hdr_s io_resp_hdr;
  io_data_t     io_resp_data;
  logic         io_resp_v;
  logic         io_resp_ready;

  axil_write_capture u_wr_capture
    (.clk_i          (clk_i)
    , .rst_n_i       (rst_n_i)
    , .s_awaddr_i    (s_awaddr_i)
    , .s_awvalid_i   (s_awvalid_i)
    , .s_awready_o   (s_awready_o)
    , .s_wdata_i     (s_wdata_i)
    , .s_wstrb_i     (s_wstrb_i)
    , .s_wvalid_i    (s_wvalid_i)
    , .s_wready_o    (s_wready_o)
    , .s_bresp_o     (s_bresp_o)
    , .s_bvalid_o    (s_bvalid_o)
    , .s_bready_i    (s_bready_i)
    , .wr_req_o      (wr_req)
    , .wr_req_v_o    (wr_req_v)
    , .wr_req_ready_i(wr_req_ready)
    , .b_i           (b)
    , .b_v_i         (b_v)
    , .b_ready_o     (b_ready)
    );

  axil_read_capture u_rd_capture
    (.clk_i          (clk_i)
    , .rst_n_i       (rst_n_i)
    , .s_araddr_i    (s_araddr_i)
    , .s_arvalid_i   (s_arvalid_i)
    , .s_arready_o   (s_arready_o)
    , .s_rdata_o     (s_rdata_o)
    , .s_rresp_o     (s_rresp_o)
    , .s_rvalid_o    (s_rvalid_o)
    , .s_rready_i    (s_rready_i)
    , .rd_req_o      (rd_req)
    , .rd_req_v_o    (rd_req_v)
    , .rd_req_ready_i(rd_req_ready)
    , .r_i           (r)
    , .r_v_i         (r_v)
    , .r_ready_o     (r_ready)
    );

  io_cmd_arbiter u_arbiter
    (.clk_i           (clk_i)
    , .rst_n_i        (rst_n_i)
    , .wr_req_i       (wr_req)
    , .wr_req_v_i     (wr_req_v)
    , .wr_req_ready_o (wr_req_ready)
    , .rd_req_i       (rd_req)
    , .rd_req_v_i     (rd_req_v)
    , .rd_req_ready_o (rd_req_ready)
    , .b_o            (b)
    , .b_v_o          (b_v)
    , .b_ready_i      (b_ready)
    , .r_o            (r)
    , .r_v_o          (r_v)
    , .r_ready_i      (r_ready)
    , .io_cmd_hdr_o   (io_cmd_hdr)
    , .io_cmd_data_o  (io_cmd_data)
    , .io_cmd_v_o     (io_cmd_v)
    , .io_cmd_ready_i (io_cmd_ready)
    , .io_resp_hdr_i  (io_resp_hdr)
    , .io_resp_data_i (io_resp_data)
    , .io_resp_v_i    (io_resp_v)
    , .io_resp_ready_o(io_resp_ready)
    );

  io_scratch_mem u_mem
    (.clk_i           (clk_i)
    , .rst_n_i        (rst_n_i)
    , .io_cmd_hdr_i   (io_cmd_hdr)
    , .io_cmd_data_i  (io_cmd_data)
    , .io_cmd_v_i     (io_cmd_v)
    , .io_cmd_ready_o (io_cmd_ready)
    , .io_resp_hdr_o  (io_resp_hdr)
    , .io_resp_data_o (io_resp_data)
    , .io_resp_v_o    (io_resp_v)
    , .io_resp_ready_i(io_resp_ready)
    );

endmodule

`default_nettype wire

/* dv/axil_io_checker.sv */
`default_nettype none

`include "axil_io_bridge_config.svh"

module axil_io_checker
  (input  wire                    clk_i
  , input  wire                   rst_n_i
  , input  axil_pkg::axil_addr_t  awaddr_i
  , input  wire                   awvalid_i
  , input  wire                   awready_i
  , input  axil_pkg::axil_data_t  wdata_i
  , input  axil_pkg::axil_strb_t  wstrb_i
  , input  wire                   wvalid_i
  , input  wire                   wready_i
  , input  axil_pkg::axil_resp_e  bresp_i
  , input  wire                   bvalid_i
  , input  wire                   bready_i
  , input  axil_pkg::axil_addr_t  araddr_i
  , input  wire                   arvalid_i
  , input  wire                   arready_i
  , input  axil_pkg::axil_data_t  rdata_i
  , input  axil_pkg::axil_resp_e  rresp_i
  , input  wire                   rvalid_i
  , input  wire                   rready_i
  , output int                    errors_o
  , output int                    b_count_o
  , output int                    r_count_o
  , output int                    pending_o
  );

  import axil_pkg::*;

  axil_data_t model_mem [`IO_MEM_WORDS];

  // AW and W halves wait here until both have arrived
  axil_addr_t aw_q [$];
  axil_data_t wd_q [$];
  axil_strb_t ws_q [$];

  axil_resp_e exp_b_q [$];
  axil_r_s    exp_r_q [$];

  int err_cnt = 0;
  int b_cnt = 0;
  int r_cnt = 0;
  int pend_cnt = 0;

  assign errors_o  = err_cnt;
  assign b_count_o = b_cnt;
  assign r_count_o = r_cnt;
  assign pending_o = pend_cnt;

  function automatic logic out_of_range(input axil_addr_t addr);
    return (addr >> 2) >= `IO_MEM_WORDS;
  endfunction

  // Strobe 1 and 3 touch the low lanes, anything else the whole word
  function automatic axil_data_t merge_write(input axil_data_t old_word,
                                             input axil_data_t data,
                                             input axil_strb_t strb);
    axil_data_t res;
    res = data;
    if (strb == 4'h1)
      res = {old_word[31:8], data[7:0]};
    else if (strb == 4'h3)
      res = {old_word[31:16], data[15:0]};
    return res;
  endfunction

  task automatic apply_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb);
    int idx;
    if (out_of_range(addr))
      exp_b_q.push_back(SLVERR);
    else
    begin
      idx = int'(addr >> 2);
      model_mem[idx] = merge_write(model_mem[idx], data, strb);
      exp_b_q.push_back(OKAY);
    end
  endtask

  task automatic predict_read(input axil_addr_t addr);
    axil_r_s exp_r;
    if (out_of_range(addr))
    begin
      exp_r.data = '0;
      exp_r.resp = SLVERR;
    end
    else
    begin
      exp_r.data = model_mem[int'(addr >> 2)];
      exp_r.resp = OKAY;
    end
    exp_r_q.push_back(exp_r);
  endtask

  task automatic check_b();
    axil_resp_e exp_b;
    if (exp_b_q.size() == 0)
    begin
      $display("A B beat arrived with no write outstanding at time %0t", $time);
      err_cnt++;
    end
    else
    begin
      exp_b = exp_b_q.pop_front();
      b_cnt++;
      if (bresp_i != exp_b)
      begin
        $display("ERROR at %0t: bresp %0d, expected %0d", $time, bresp_i, exp_b);
        err_cnt++;
      end
    end
  endtask

  task automatic check_r();
    axil_r_s exp_r;
    if (exp_r_q.size() == 0)
    begin
      $display("An R beat arrived with no read outstanding at time %0t", $time);
      err_cnt++;
    end
    else
    begin
      exp_r = exp_r_q.pop_front();
      r_cnt++;
      if (rresp_i != exp_r.resp || rdata_i != exp_r.data)
      begin
        $display("ERROR at %0t: rdata %h rresp %0d, expected %h rresp %0d",
                 $time, rdata_i, rresp_i, exp_r.data, exp_r.resp);
        err_cnt++;
      end
    end
  endtask

  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `IO_MEM_WORDS; i++)
        model_mem[i] = '0;
      aw_q.delete();
      wd_q.delete();
      ws_q.delete();
      exp_b_q.delete();
      exp_r_q.delete();
    end
    else
    begin
      if (awvalid_i && awready_i)
        aw_q.push_back(awaddr_i);
      if (wvalid_i && wready_i)
      begin
        wd_q.push_back(wdata_i);
        ws_q.push_back(wstrb_i);
      end
      if (aw_q.size() != 0 && wd_q.size() != 0)
        apply_write(aw_q.pop_front(), wd_q.pop_front(), ws_q.pop_front());
      if (arvalid_i && arready_i)
        predict_read(araddr_i);
      if (bvalid_i && bready_i)
        check_b();
      if (rvalid_i && rready_i)
        check_r();
    end
    pend_cnt = aw_q.size() + wd_q.size() + exp_b_q.size() + exp_r_q.size();
  end

endmodule

`default_nettype wire

/* dv/tb_axil_io_bridge.sv */
`default_nettype none

module tb_axil_io_bridge;

  import axil_pkg::*;

  localparam int wait_limit_lp = 200;

  logic       clk;
  logic       rst_n;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wvalid;
  logic       wready;
  axil_resp_e bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  axil_resp_e rresp;
  logic       rvalid;
  logic       rready;

  logic [31:0] main_lfsr;
  logic [31:0] rd_lfsr;
  int          tb_errors;
  int          timeouts;
  int          chk_errors;
  int          b_count;
  int          r_count;
  int          pending;

  axil_io_bridge_top u_dut
    (.clk_i        (clk)
    , .rst_n_i     (rst_n)
    , .s_awaddr_i  (awaddr)
    , .s_awvalid_i (awvalid)
    , .s_awready_o (awready)
    , .s_wdata_i   (wdata)
    , .s_wstrb_i   (wstrb)
    , .s_wvalid_i  (wvalid)
    , .s_wready_o  (wready)
    , .s_bresp_o   (bresp)
    , .s_bvalid_o  (bvalid)
    , .s_bready_i  (bready)
    , .s_araddr_i  (araddr)
    , .s_arvalid_i (arvalid)
    , .s_arready_o (arready)
    , .s_rdata_o   (rdata)
    , .s_rresp_o   (rresp)
    , .s_rvalid_o  (rvalid)
    , .s_rready_i  (rready)
    );

  axil_io_checker u_checker
    (.clk_i      (clk)
    , .rst_n_i   (rst_n)
    , .awaddr_i  (awaddr)
    , .awvalid_i (awvalid)
    , .awready_i (awready)
    , .wdata_i   (wdata)
    , .wstrb_i   (wstrb)
    , .wvalid_i  (wvalid)
    , .wready_i  (wready)
    , .bresp_i   (bresp)
    , .bvalid_i  (bvalid)
    , .bready_i  (bready)
    , .araddr_i  (araddr)
    , .arvalid_i (arvalid)
    , .arready_i (arready)
    , .rdata_i   (rdata)
    , .rresp_i   (rresp)
    , .rvalid_i  (rvalid)
    , .rready_i  (rready)
    , .errors_o  (chk_errors)
    , .b_count_o (b_count)
    , .r_count_o (r_count)
    , .pending_o (pending)
    );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic take_bit(inout logic [31:0] st);
    logic b;
    b = st[0];
    st = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
    return b;
  endfunction

  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], take_bit(st)};
    return v;
  endfunction

  // Region 1 keeps to the low half of the memory, region 2 to the high half
  function automatic axil_addr_t pick_addr(inout logic [31:0] st, input int region);
    logic [7:0]  idx;
    logic [21:0] hi;
    idx = 8'(take_bits(st, 8));
    hi  = 22'(take_bits(st, 22));
    // About one access in eight lands above the memory
    if (3'(take_bits(st, 3)) == 3'd0)
      return {hi | 22'h1, idx, 2'b00};
    if (region == 1)
      idx[7] = 1'b0;
    else if (region == 2)
      idx[7] = 1'b1;
    return {22'h0, idx, 2'b00};
  endfunction

  function automatic axil_strb_t pick_strb(inout logic [31:0] st);
    logic [1:0] kind;
    kind = 2'(take_bits(st, 2));
    case (kind)
      2'd0:    return 4'h1;
      2'd1:    return 4'h3;
      2'd2:    return 4'hF;
      default: return axil_strb_t'(take_bits(st, 4));
    endcase
  endfunction

  task automatic finish_run();
    int total;
    if (pending != 0)
      $display("Transactions still unanswered at the end of the run: %0d", pending);
    total = chk_errors + tb_errors + timeouts + pending;
    $display("Summary: %0d checker errors, %0d testbench errors, %0d timeouts, %0d B, %0d R",
             chk_errors, tb_errors, timeouts, b_count, r_count);
    if (total == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  task automatic report_timeout(input string chan);
    $display("Timed out waiting for the %s handshake at time %0t", chan, $time);
    timeouts++;
    finish_run();
  endtask

  task automatic drive_aw(input axil_addr_t addr);
    int waited;
    waited = 0;
    awaddr  <= addr;
    awvalid <= 1'b1;
    @(posedge clk);
    while (!awready && waited < wait_limit_lp)
    begin
      waited++;
      @(posedge clk);
    end
    if (!awready)
      report_timeout("AW");
    else
      awvalid <= 1'b0;
  endtask

  task automatic drive_w(input axil_data_t data, input axil_strb_t strb);
    int waited;
    waited = 0;
    wdata  <= data;
    wstrb  <= strb;
    wvalid <= 1'b1;
    @(posedge clk);
    while (!wready && waited < wait_limit_lp)
    begin
      waited++;
      @(posedge clk);
    end
    if (!wready)
      report_timeout("W");
    else
      wvalid <= 1'b0;
  endtask

  task automatic drive_ar(input axil_addr_t addr);
    int waited;
    waited = 0;
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge clk);
    while (!arready && waited < wait_limit_lp)
    begin
      waited++;
      @(posedge clk);
    end
    if (!arready)
      report_timeout("AR");
    else
      arvalid <= 1'b0;
  endtask

  // With stall set, bready flips at random each cycle
  task automatic collect_b(input logic stall, inout logic [31:0] st);
    int waited;
    waited = 0;
    bready <= stall ? take_bit(st) : 1'b1;
    @(posedge clk);
    while (!(bvalid && bready) && waited < wait_limit_lp)
    begin
      waited++;
      bready <= stall ? take_bit(st) : 1'b1;
      @(posedge clk);
    end
    if (!(bvalid && bready))
      report_timeout("B");
    else
      bready <= 1'b0;
  endtask

  // Cycles counts the clock edges from the AR handshake to the R handshake
  task automatic collect_r(input logic stall, inout logic [31:0] st, output int cycles);
    int waited;
    waited = 0;
    cycles = 0;
    rready <= stall ? take_bit(st) : 1'b1;
    @(posedge clk);
    while (!(rvalid && rready) && waited < wait_limit_lp)
    begin
      waited++;
      rready <= stall ? take_bit(st) : 1'b1;
      @(posedge clk);
    end
    if (!(rvalid && rready))
      report_timeout("R");
    else
    begin
      cycles = waited + 1;
      rready <= 1'b0;
    end
  endtask

  // Order 0 sends AW first, 1 sends W first, anything else both together
  task automatic write_txn(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb, input int order,
                           input logic stall, inout logic [31:0] st);
    case (order)
      0:
      begin
        drive_aw(addr);
        drive_w(data, strb);
      end
      1:
      begin
        drive_w(data, strb);
        drive_aw(addr);
      end
      default:
        fork
          drive_aw(addr);
          drive_w(data, strb);
        join
    endcase
    collect_b(stall, st);
  endtask

  task automatic read_txn(input axil_addr_t addr, input logic stall,
                          inout logic [31:0] st, output int cycles);
    drive_ar(addr);
    collect_r(stall, st, cycles);
  endtask

  // Mode 0 mixes reads and writes anywhere, 1 writes the low half, 2 reads the high half
  task automatic run_random(input int n, input int mode, inout logic [31:0] st);
    logic       is_wr;
    logic       stall;
    int         gap;
    int         order;
    int         cycles;
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    for (int i = 0; i < n; i++)
    begin
      gap   = int'(take_bits(st, 2));
      stall = take_bit(st);
      is_wr = (mode == 1) || (mode == 0 && take_bit(st));
      repeat (gap) @(posedge clk);
      if (is_wr)
      begin
        addr  = pick_addr(st, mode);
        data  = take_bits(st, 32);
        strb  = pick_strb(st);
        order = int'(take_bits(st, 2));
        write_txn(addr, data, strb, order, stall, st);
      end
      else
      begin
        addr = pick_addr(st, mode);
        read_txn(addr, stall, st, cycles);
      end
    end
  endtask

  initial
  begin
    int cycles;
    main_lfsr = 32'h5ee0;
    rd_lfsr   = '0;
    tb_errors = 0;
    timeouts  = 0;
    rst_n     = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (!(awready && wready && arready && !bvalid && !rvalid))
    begin
      $display("ERROR at %0t: ready or valid outputs wrong after reset", $time);
      tb_errors++;
    end

    // Full word round trip
    write_txn(32'h40, 32'hcafe_f00d, 4'hF, 0, 1'b0, main_lfsr);
    read_txn(32'h40, 1'b0, main_lfsr, cycles);

    // Sized writes then readback
    write_txn(32'h44, 32'h1122_3344, 4'hF, 0, 1'b0, main_lfsr);
    write_txn(32'h44, 32'haaaa_aa55, 4'h1, 0, 1'b0, main_lfsr);
    read_txn(32'h44, 1'b0, main_lfsr, cycles);
    write_txn(32'h44, 32'hbbbb_6677, 4'h3, 1, 1'b0, main_lfsr);
    read_txn(32'h44, 1'b0, main_lfsr, cycles);
    write_txn(32'h44, 32'hdead_beef, 4'h5, 2, 1'b0, main_lfsr);
    read_txn(32'h44, 1'b0, main_lfsr, cycles);

    // Out of range, high bits must not alias onto word 0x11
    write_txn(32'h0000_0400, 32'h0bad_0bad, 4'hF, 0, 1'b0, main_lfsr);
    read_txn(32'h0000_0400, 1'b0, main_lfsr, cycles);
    write_txn(32'h8000_0044, 32'h5555_5555, 4'hF, 2, 1'b0, main_lfsr);
    read_txn(32'h44, 1'b0, main_lfsr, cycles);

    // All three AW and W orders
    write_txn(32'h80, 32'h0101_0101, 4'hF, 0, 1'b0, main_lfsr);
    write_txn(32'h84, 32'h0202_0202, 4'hF, 1, 1'b0, main_lfsr);
    write_txn(32'h88, 32'h0303_0303, 4'hF, 2, 1'b0, main_lfsr);
    read_txn(32'h80, 1'b0, main_lfsr, cycles);
    read_txn(32'h84, 1'b0, main_lfsr, cycles);
    read_txn(32'h88, 1'b0, main_lfsr, cycles);

    read_txn(32'h40, 1'b0, main_lfsr, cycles);
    if (cycles != 4)
    begin
      $display("ERROR at %0t: read latency %0d cycles, expected 4", $time, cycles);
      tb_errors++;
    end

    run_random(60, 0, main_lfsr);

    // Writes and reads in flight together, on disjoint halves of the memory
    rd_lfsr = take_bits(main_lfsr, 32);
    fork
      run_random(40, 1, main_lfsr);
      run_random(40, 2, rd_lfsr);
    join

    repeat (5) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

/* axil_io_bridge.f */
+incdir+hw
hw/axil_pkg.sv
hw/io_bus_pkg.sv
hw/axil_write_capture.sv
hw/axil_read_capture.sv
hw/io_cmd_arbiter.sv
hw/io_scratch_mem.sv
hw/axil_io_bridge_top.sv
dv/axil_io_checker.sv
dv/tb_axil_io_bridge.sv

/* Makefile */
# Verilator build and run for the AXI4-Lite I/O bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axil_io_bridge
FILELIST  ?= axil_io_bridge.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
